/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int unsigned DATA_WIDTH      = 32;   // Machine word
    localparam int unsigned INST_ADDR_WIDTH = 32;   // Byte address of an instruction
    localparam int unsigned REG_ADDR_WIDTH  = 5;    // 32 architectural registers

    // Data memory geometry, counted in 32-bit words
    localparam int unsigned DMEM_DEPTH     = 64;
    localparam int unsigned DMEM_ADDR_BITS = 6;

    localparam int unsigned PC_STEP = 4;            // Bytes per instruction

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;

    // ALU operation codes carried from decode
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_RESULT   = 2'd0,                         // ALU output
        WB_LOAD     = 2'd1,                         // Data memory word
        WB_PC_PLUS4 = 2'd2                          // Link address
    } wb_sel_e;

endpackage

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  cpu_pkg::alu_op_e i_alu_op,      // Operation from decode
    input  cpu_pkg::data_t   i_operand_a,   // First source operand
    input  cpu_pkg::data_t   i_operand_b,   // Second source operand or immediate
    output cpu_pkg::data_t   o_result       // ALU output
);

    import cpu_pkg::*;

    logic [4:0] shift_amount;               // Only 5 bits matter for a 32-bit word
    data_t      sum;
    data_t      difference;
    data_t      bit_and;
    data_t      bit_or;
    data_t      bit_xor;
    data_t      shift_left;
    data_t      shift_right;
    logic       less_than;                  // Signed comparison

    assign shift_amount = i_operand_b[4:0];

    // Arithmetic
    assign sum        = i_operand_a + i_operand_b;
    assign difference = i_operand_a - i_operand_b;

    // Logic
    assign bit_and = i_operand_a & i_operand_b;
    assign bit_or  = i_operand_a | i_operand_b;
    assign bit_xor = i_operand_a ^ i_operand_b;

    // Logical shifts, zero fill
    assign shift_left  = i_operand_a << shift_amount;
    assign shift_right = i_operand_a >> shift_amount;

    assign less_than = $signed(i_operand_a) < $signed(i_operand_b);

    always_comb begin
        case (i_alu_op)
            ALU_ADD: begin
                o_result = sum;
            end
            ALU_SUB: begin
                o_result = difference;
            end
            ALU_AND: begin
                o_result = bit_and;
            end
            ALU_OR: begin
                o_result = bit_or;
            end
            ALU_XOR: begin
                o_result = bit_xor;
            end
            ALU_SLL: begin
                o_result = shift_left;
            end
            ALU_SRL: begin
                o_result = shift_right;
            end
            ALU_SLT: begin
                o_result = {{(DATA_WIDTH-1){1'b0}}, less_than};   // 1 or 0
            end
            default: begin
                o_result = sum;             // Unused codes behave as add
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/ex_mem_register.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_register (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_flush,            // Cancels the write actions
    input  cpu_pkg::inst_addr_t i_pc,
    input  cpu_pkg::data_t      i_result,
    input  cpu_pkg::data_t      i_store_data,
    input  logic                i_mem_wr_enable,
    input  cpu_pkg::reg_addr_t  i_reg_wr_addr,
    input  logic                i_reg_wr_enable,
    input  cpu_pkg::wb_sel_e    i_wb_sel,
    output cpu_pkg::inst_addr_t o_pc,
    output cpu_pkg::data_t      o_result,
    output cpu_pkg::data_t      o_store_data,
    output logic                o_mem_wr_enable,
    output cpu_pkg::reg_addr_t  o_reg_wr_addr,
    output logic                o_reg_wr_enable,
    output cpu_pkg::wb_sel_e    o_wb_sel
);

    import cpu_pkg::*;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_pc            <= '0;
            o_result        <= '0;
            o_store_data    <= '0;
            o_mem_wr_enable <= 1'b0;
            o_reg_wr_addr   <= '0;
            o_reg_wr_enable <= 1'b0;
            o_wb_sel        <= WB_RESULT;
        end else begin
            o_pc            <= i_pc;
            o_result        <= i_result;
            o_store_data    <= i_store_data;
            o_reg_wr_addr   <= i_reg_wr_addr;
            o_wb_sel        <= i_wb_sel;
            // A flushed instruction moves on as a bubble
            o_mem_wr_enable <= i_flush ? 1'b0 : i_mem_wr_enable;
            o_reg_wr_enable <= i_flush ? 1'b0 : i_reg_wr_enable;
        end
    end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic                i_clock,
    input  logic                i_reset,
    input  cpu_pkg::inst_addr_t i_pc,
    input  cpu_pkg::data_t      i_result,            // Address for loads and stores
    input  cpu_pkg::data_t      i_store_data,
    input  logic                i_mem_wr_enable,
    input  cpu_pkg::reg_addr_t  i_reg_wr_addr,
    input  logic                i_reg_wr_enable,
    input  cpu_pkg::wb_sel_e    i_wb_sel,
    output cpu_pkg::data_t      o_wb_data,
    output cpu_pkg::reg_addr_t  o_wb_reg_addr,
    output logic                o_wb_reg_wr_enable
);

    import cpu_pkg::*;

    data_t                     dmem [DMEM_DEPTH];    // Word-wide data memory
    logic [DMEM_ADDR_BITS-1:0] word_index;
    data_t                     load_data;
    data_t                     pc_plus4;
    data_t                     wb_data_next;

    // Byte address to word index, low two bits ignored
    assign word_index = i_result[DMEM_ADDR_BITS+1:2];

    // Asynchronous read returns the word before this edge's store
    assign load_data = dmem[word_index];

    assign pc_plus4 = i_pc + PC_STEP;

    always_ff @(posedge i_clock) begin
        if (i_mem_wr_enable) begin
            dmem[word_index] <= i_store_data;
        end
    end

    always_comb begin
        case (i_wb_sel)
            WB_RESULT: begin
                wb_data_next = i_result;
            end
            WB_LOAD: begin
                wb_data_next = load_data;
            end
            WB_PC_PLUS4: begin
                wb_data_next = pc_plus4;    // Return address for jumps
            end
            default: begin
                wb_data_next = i_result;
            end
        endcase
    end

    // Write-back register, plays the part of MEM/WB
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb_data          <= '0;
            o_wb_reg_addr      <= '0;
            o_wb_reg_wr_enable <= 1'b0;
        end else begin
            o_wb_data          <= wb_data_next;
            o_wb_reg_addr      <= i_reg_wr_addr;
            o_wb_reg_wr_enable <= i_reg_wr_enable;
        end
    end

endmodule

`default_nettype wire

/* design/exec_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_mem_top (
    input  logic                i_clock,
    input  logic                i_reset,
    input  cpu_pkg::inst_addr_t i_pc,
    input  cpu_pkg::alu_op_e    i_alu_op,
    input  cpu_pkg::data_t      i_operand_a,
    input  cpu_pkg::data_t      i_operand_b,
    input  cpu_pkg::data_t      i_store_data,
    input  logic                i_mem_wr_enable,
    input  cpu_pkg::reg_addr_t  i_reg_wr_addr,
    input  logic                i_reg_wr_enable,
    input  cpu_pkg::wb_sel_e    i_wb_sel,
    input  logic                i_flush,
    output cpu_pkg::data_t      o_wb_data,
    output cpu_pkg::reg_addr_t  o_wb_reg_addr,
    output logic                o_wb_reg_wr_enable
);

    import cpu_pkg::*;

    data_t      ex_result;                  // Combinational ALU output

    // EX/MEM register outputs
    inst_addr_t mem_pc;
    data_t      mem_result;
    data_t      mem_store_data;
    logic       mem_mem_wr_enable;
    reg_addr_t  mem_reg_wr_addr;
    logic       mem_reg_wr_enable;
    wb_sel_e    mem_wb_sel;

    execute_stage u_execute_stage (
        .i_alu_op    (i_alu_op),
        .i_operand_a (i_operand_a),
        .i_operand_b (i_operand_b),
        .o_result    (ex_result)
    );

    ex_mem_register u_ex_mem_register (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_flush         (i_flush),
        .i_pc            (i_pc),
        .i_result        (ex_result),
        .i_store_data    (i_store_data),
        .i_mem_wr_enable (i_mem_wr_enable),
        .i_reg_wr_addr   (i_reg_wr_addr),
        .i_reg_wr_enable (i_reg_wr_enable),
        .i_wb_sel        (i_wb_sel),
        .o_pc            (mem_pc),
        .o_result        (mem_result),
        .o_store_data    (mem_store_data),
        .o_mem_wr_enable (mem_mem_wr_enable),
        .o_reg_wr_addr   (mem_reg_wr_addr),
        .o_reg_wr_enable (mem_reg_wr_enable),
        .o_wb_sel        (mem_wb_sel)
    );

    memory_stage u_memory_stage (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_pc               (mem_pc),
        .i_result           (mem_result),
        .i_store_data       (mem_store_data),
        .i_mem_wr_enable    (mem_mem_wr_enable),
        .i_reg_wr_addr      (mem_reg_wr_addr),
        .i_reg_wr_enable    (mem_reg_wr_enable),
        .i_wb_sel           (mem_wb_sel),
        .o_wb_data          (o_wb_data),
        .o_wb_reg_addr      (o_wb_reg_addr),
        .o_wb_reg_wr_enable (o_wb_reg_wr_enable)
    );

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter int CLOCK_PERIOD = 20,        // ns
    parameter int RESET_CYCLES = 16
) (
    output logic o_clock,
    output logic o_reset
);

    initial begin
        o_clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) o_clock = ~o_clock;
        end
    end

    // Released 2 ns after an edge, like every other input
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #2 o_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_exec_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_mem;

    import cpu_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int ALU_COUNT    = 300;
    localparam int LOAD_COUNT   = 100;
    localparam int FLUSH_COUNT  = 200;
    localparam int LINK_COUNT   = 50;
    localparam int PAIR_COUNT   = 40;
    // One cycle per instruction plus two to drain
    localparam int TEST_CYCLES  = RESET_CYCLES + ALU_COUNT + DMEM_DEPTH + LOAD_COUNT
                                + FLUSH_COUNT + DMEM_DEPTH + LINK_COUNT + 2 * PAIR_COUNT + 2;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 50;

    logic       clock;
    logic       reset;
    inst_addr_t pc;
    alu_op_e    alu_op;
    data_t      operand_a;
    data_t      operand_b;
    data_t      store_data;
    logic       mem_wr_enable;
    reg_addr_t  reg_wr_addr;
    logic       reg_wr_enable;
    wb_sel_e    wb_sel;
    logic       flush;
    data_t      wb_data;
    reg_addr_t  wb_reg_addr;
    logic       wb_reg_wr_enable;

    integer     seed = 37560;
    int         cycle_count = 0;
    data_t      mem_model [DMEM_DEPTH];     // Memory image in program order

    // Expected outputs with the oldest first
    data_t      exp_data_q [$];
    reg_addr_t  exp_addr_q [$];
    logic       exp_enable_q [$];
    string      exp_name_q [$];

    clock_gen #(.CLOCK_PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .o_clock (clock),
        .o_reset (reset)
    );

    exec_mem_top uut (
        .i_clock            (clock),
        .i_reset            (reset),
        .i_pc               (pc),
        .i_alu_op           (alu_op),
        .i_operand_a        (operand_a),
        .i_operand_b        (operand_b),
        .i_store_data       (store_data),
        .i_mem_wr_enable    (mem_wr_enable),
        .i_reg_wr_addr      (reg_wr_addr),
        .i_reg_wr_enable    (reg_wr_enable),
        .i_wb_sel           (wb_sel),
        .i_flush            (flush),
        .o_wb_data          (wb_data),
        .o_wb_reg_addr      (wb_reg_addr),
        .o_wb_reg_wr_enable (wb_reg_wr_enable)
    );

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: wb data expected %h, actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "write-back data mismatch");
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t expected,
                                  input reg_addr_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: wb register expected %0d, actual %0d", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "write-back register mismatch");
        end
    endtask

    task automatic check_enable(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: wb enable expected %b, actual %b", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "write-back enable mismatch");
        end
    endtask

    function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
        data_t value;
        case (op)
            ALU_ADD: value = a + b;
            ALU_SUB: value = a - b;
            ALU_AND: value = a & b;
            ALU_OR:  value = a | b;
            ALU_XOR: value = a ^ b;
            ALU_SLL: value = a << b[4:0];
            ALU_SRL: value = a >> b[4:0];
            ALU_SLT: begin
                if (a[31] != b[31]) begin
                    value = {31'b0, a[31]};         // Signs differ so the negative one is less
                end else begin
                    value = {31'b0, a < b};
                end
            end
            default: value = 'x;
        endcase
        return value;
    endfunction

    task automatic compare_oldest();
        string name;
        name = exp_name_q.pop_front();
        check_data(name, exp_data_q.pop_front(), wb_data);
        check_reg_addr(name, exp_addr_q.pop_front(), wb_reg_addr);
        check_enable(name, exp_enable_q.pop_front(), wb_reg_wr_enable);
    endtask

    // Checks the output due this cycle and then drives the next instruction
    task automatic issue(input string name, input inst_addr_t new_pc, input alu_op_e op,
                         input data_t a, input data_t b, input data_t wr_data,
                         input logic mem_wr, input reg_addr_t rd, input logic rd_enable,
                         input wb_sel_e sel, input logic cancel);
        data_t                     result;
        data_t                     expected;
        logic [DMEM_ADDR_BITS-1:0] index;
        @(posedge clock);
        #1;
        compare_oldest();
        #1;
        pc            = new_pc;
        alu_op        = op;
        operand_a     = a;
        operand_b     = b;
        store_data    = wr_data;
        mem_wr_enable = mem_wr;
        reg_wr_addr   = rd;
        reg_wr_enable = rd_enable;
        wb_sel        = sel;
        flush         = cancel;
        result = alu_model(op, a, b);
        index  = result[7:2];                       // Word index
        case (sel)
            WB_LOAD:     expected = mem_model[index];   // Read before own store
            WB_PC_PLUS4: expected = new_pc + 32'd4;
            default:     expected = result;
        endcase
        if (mem_wr && !cancel) begin
            mem_model[index] = wr_data;
        end
        exp_data_q.push_back(expected);
        exp_addr_q.push_back(rd);
        exp_enable_q.push_back(rd_enable && !cancel);
        exp_name_q.push_back(name);
    endtask

    // Operands whose sum lands on the given word with other address bits random
    task automatic access_operands(input logic [DMEM_ADDR_BITS-1:0] index,
                                   output data_t a, output data_t b);
        data_t target;
        target      = $random(seed);
        target[7:2] = index;
        a           = $random(seed);
        b           = target - a;
    endtask

    task automatic do_store(input string name, input logic [DMEM_ADDR_BITS-1:0] index,
                            input data_t value, input logic cancel);
        data_t a;
        data_t b;
        data_t control;
        access_operands(index, a, b);
        control = $random(seed);
        issue(name, $random(seed), ALU_ADD, a, b, value, 1'b1, control[4:0], 1'b0,
              WB_RESULT, cancel);
    endtask

    task automatic do_load(input string name, input logic [DMEM_ADDR_BITS-1:0] index,
                           input logic cancel);
        data_t a;
        data_t b;
        data_t control;
        access_operands(index, a, b);
        control = $random(seed);
        issue(name, $random(seed), ALU_ADD, a, b, $random(seed), 1'b0, control[4:0], 1'b1,
              WB_LOAD, cancel);
    endtask

    task automatic run_alu_tests();
        data_t control;
        for (int i = 0; i < ALU_COUNT; i++) begin
            control = $random(seed);
            issue($sformatf("alu %0d", i), $random(seed), alu_op_e'({1'b0, control[2:0]}),
                  $random(seed), $random(seed), $random(seed), 1'b0, control[12:8],
                  control[16], WB_RESULT, 1'b0);
        end
    endtask

    task automatic run_memory_tests();
        data_t control;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            do_store($sformatf("store %0d", i), i[DMEM_ADDR_BITS-1:0], $random(seed), 1'b0);
        end
        for (int i = 0; i < LOAD_COUNT; i++) begin
            control = $random(seed);
            do_load($sformatf("load %0d", i), control[DMEM_ADDR_BITS-1:0], 1'b0);
        end
    endtask

    task automatic run_flush_tests();
        data_t control;
        logic  cancel;
        for (int i = 0; i < FLUSH_COUNT; i++) begin
            control = $random(seed);
            cancel  = (control[5:4] == 2'b00);     // About one in four
            case (control[1:0])
                2'd0: issue($sformatf("flush alu %0d", i), $random(seed),
                            alu_op_e'({1'b0, control[10:8]}), $random(seed), $random(seed),
                            $random(seed), 1'b0, control[20:16], 1'b1, WB_RESULT, cancel);
                2'd1: do_store($sformatf("flush store %0d", i), control[29:24],
                               $random(seed), cancel);
                default: do_load($sformatf("flush load %0d", i), control[29:24], cancel);
            endcase
        end
        // Sweep confirms no cancelled store landed
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            do_load($sformatf("flush sweep %0d", i), i[DMEM_ADDR_BITS-1:0], 1'b0);
        end
    endtask

    task automatic run_link_tests();
        data_t control;
        for (int i = 0; i < LINK_COUNT; i++) begin
            control = $random(seed);
            issue($sformatf("link %0d", i), $random(seed), alu_op_e'({1'b0, control[2:0]}),
                  $random(seed), $random(seed), $random(seed), 1'b0, control[12:8], 1'b1,
                  WB_PC_PLUS4, 1'b0);
        end
    endtask

    task automatic run_back_to_back();
        data_t control;
        for (int i = 0; i < PAIR_COUNT; i++) begin
            control = $random(seed);
            do_store($sformatf("pair store %0d", i), control[DMEM_ADDR_BITS-1:0],
                     $random(seed), 1'b0);
            do_load($sformatf("pair load %0d", i), control[DMEM_ADDR_BITS-1:0], 1'b0);
        end
    endtask

    task automatic drain_pipeline();
        repeat (2) begin
            @(posedge clock);
            #1;
            compare_oldest();
            #1;
            mem_wr_enable = 1'b0;
            reg_wr_enable = 1'b0;
            flush         = 1'b0;
        end
    endtask

    initial begin
        pc            = '0;
        alu_op        = ALU_ADD;
        operand_a     = '0;
        operand_b     = '0;
        store_data    = '0;
        mem_wr_enable = 1'b0;
        reg_wr_addr   = '0;
        reg_wr_enable = 1'b0;
        wb_sel        = WB_RESULT;
        flush         = 1'b0;
        // Reset contents and the idle input both drain out as zero
        repeat (2) begin
            exp_data_q.push_back('0);
            exp_addr_q.push_back('0);
            exp_enable_q.push_back(1'b0);
            exp_name_q.push_back("after reset");
        end
        repeat (RESET_CYCLES) begin
            @(posedge clock);
            #1;
            check_data("reset", '0, wb_data);
            check_reg_addr("reset", '0, wb_reg_addr);
            check_enable("reset", 1'b0, wb_reg_wr_enable);
        end
        wait (!reset);
        run_alu_tests();
        run_memory_tests();
        run_flush_tests();
        run_link_tests();
        run_back_to_back();
        drain_pipeline();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/cpu_pkg.sv
design/execute_stage.sv
design/ex_mem_register.sv
design/memory_stage.sv
design/exec_mem_top.sv
verif/clock_gen.sv
verif/tb_exec_mem.sv
